// File: wb_pkg.sv
// Wishbone subsystem package with bus widths, cycle-type codes and bus structs
package wb_pkg;

        //////////////////////////////////////////////////
        // Widths that carry a meaning
        //////////////////////////////////////////////////

        // One data word on the bus
        typedef logic [31:0] word_t;

        // Byte address, the SRAM ignores bits 1:0
        typedef logic [31:0] addr_t;

        // One enable per byte lane
        typedef logic [3:0]  sel_t;

        // Wishbone cycle type identifier
        typedef logic [2:0]  cti_t;

        // Cycle-type codes used on the bus
        localparam cti_t CTI_CLASSIC = 3'd0;
        localparam cti_t CTI_INCR    = 3'd2;
        localparam cti_t CTI_EOB     = 3'd7;

        // Words per instruction fetch burst and the counter that walks them
        localparam int BURST_LEN = 4;
        localparam int BEAT_W    = $clog2(BURST_LEN);

        // SRAM depth in words and the matching word index width
        localparam int MEM_WORDS = 256;
        localparam int MEM_AW    = $clog2(MEM_WORDS);

        //////////////////////////////////////////////////
        // Bus structs
        //////////////////////////////////////////////////

        // Everything a master drives towards the slave
        typedef struct packed {
                logic  cyc;
                logic  stb;
                logic  wen;
                sel_t  sel;
                word_t dat;
                addr_t adr;
                cti_t  cti;
        } wb_req_t;

        // Everything the slave returns
        typedef struct packed {
                logic  ack;
                word_t dat;
        } wb_rsp_t;

        // Which master currently holds the shared bus
        typedef enum logic {OWNER_CODE, OWNER_DATA} owner_t;

endpackage

// File: code_fetch_unit.sv
// Code fetch unit, a Wishbone master reading four-word incrementing bursts
`timescale 1ns/1ps

module code_fetch_unit import wb_pkg::*;
(
        input  logic    i_clk,
        input  logic    i_reset,
        input  logic    i_start,
        input  addr_t   i_addr,
        output word_t   o_word,
        output logic    o_valid,
        output logic    o_done,
        output wb_req_t o_wb_req,
        input  logic    i_wb_ack,
        input  word_t   i_wb_dat
);

typedef enum logic {FETCH_IDLE, FETCH_BURST} fetch_state_t;

fetch_state_t      state_ff;
logic [BEAT_W-1:0] beat_ff;
addr_t             adr_ff;
cti_t              cti_ff;

// Marks the acknowledge of the final beat
logic last_beat;

assign last_beat = (beat_ff == BEAT_W'(BURST_LEN - 1));

//////////////////////////////////////////////////
// Burst control
//////////////////////////////////////////////////

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                state_ff <= FETCH_IDLE;
                beat_ff  <= '0;
                cti_ff   <= CTI_EOB;
                o_valid  <= 1'b0;
                o_done   <= 1'b0;
        end
        else
        begin
                // Both strobes are single-cycle pulses
                o_valid <= 1'b0;
                o_done  <= 1'b0;
                case (state_ff)
                FETCH_IDLE:
                begin
                        if (i_start)
                        begin
                                state_ff <= FETCH_BURST;
                                beat_ff  <= '0;
                                cti_ff   <= (BURST_LEN == 1) ? CTI_EOB : CTI_INCR;
                        end
                end
                FETCH_BURST:
                begin
                        if (i_wb_ack)
                        begin
                                o_valid <= 1'b1;
                                beat_ff <= beat_ff + 1'b1;
                                // The beat before the last switches the tag to end-of-burst
                                if (beat_ff == BEAT_W'(BURST_LEN - 2))
                                begin
                                        cti_ff <= CTI_EOB;
                                end
                                if (last_beat)
                                begin
                                        state_ff <= FETCH_IDLE;
                                        o_done   <= 1'b1;
                                        cti_ff   <= CTI_EOB;
                                end
                        end
                end
                default:
                begin
                        state_ff <= FETCH_IDLE;
                end
                endcase
        end
end

// Address and returned word, no reset needed
always_ff @(posedge i_clk)
begin
        if (state_ff == FETCH_IDLE && i_start)
        begin
                adr_ff <= {i_addr[31:2], 2'b00};
        end
        else if (state_ff == FETCH_BURST && i_wb_ack)
        begin
                adr_ff <= adr_ff + addr_t'(4);
                o_word <= i_wb_dat;
        end
end

// Bus view of the flops, reads only so write fields are constant
always_comb
begin
        o_wb_req.cyc = (state_ff == FETCH_BURST);
        o_wb_req.stb = (state_ff == FETCH_BURST);
        o_wb_req.wen = 1'b0;
        o_wb_req.sel = '1;
        o_wb_req.dat = '0;
        o_wb_req.adr = adr_ff;
        o_wb_req.cti = cti_ff;
end

endmodule

// File: data_access_unit.sv
// Data access unit, a Wishbone master doing one single read or byte write per request
`timescale 1ns/1ps

module data_access_unit import wb_pkg::*;
(
        input  logic    i_clk,
        input  logic    i_reset,
        input  logic    i_req,
        input  logic    i_wen,
        input  addr_t   i_addr,
        input  word_t   i_wdata,
        input  sel_t    i_sel,
        output word_t   o_rdata,
        output logic    o_done,
        output logic    o_busy,
        output wb_req_t o_wb_req,
        input  logic    i_wb_ack,
        input  word_t   i_wb_dat
);

logic  busy_ff;
logic  wen_ff;
sel_t  sel_ff;
word_t dat_ff;
addr_t adr_ff;

// A request is only taken while nothing is outstanding
logic accept;

assign accept = i_req & ~busy_ff;

//////////////////////////////////////////////////
// Transfer control
//////////////////////////////////////////////////

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                busy_ff <= 1'b0;
                o_done  <= 1'b0;
        end
        else
        begin
                o_done <= busy_ff & i_wb_ack;
                if (accept)
                begin
                        busy_ff <= 1'b1;
                end
                else if (i_wb_ack)
                begin
                        busy_ff <= 1'b0;
                end
        end
end

// Request fields held stable until the acknowledge
always_ff @(posedge i_clk)
begin
        if (accept)
        begin
                wen_ff <= i_wen;
                // Reads always fetch the full word
                sel_ff <= i_wen ? i_sel : '1;
                dat_ff <= i_wdata;
                adr_ff <= {i_addr[31:2], 2'b00};
        end
        if (busy_ff && i_wb_ack && !wen_ff)
        begin
                o_rdata <= i_wb_dat;
        end
end

assign o_busy = busy_ff;

// Every single transfer is tagged as its own end of burst
always_comb
begin
        o_wb_req.cyc = busy_ff;
        o_wb_req.stb = busy_ff;
        o_wb_req.wen = wen_ff;
        o_wb_req.sel = sel_ff;
        o_wb_req.dat = dat_ff;
        o_wb_req.adr = adr_ff;
        o_wb_req.cti = CTI_EOB;
end

endmodule

// File: wb_merger.sv
// Wishbone merger, round-robin arbitration of code and data masters onto one bus
`timescale 1ns/1ps

module wb_merger import wb_pkg::*;
(
        input  logic    i_clk,
        input  logic    i_reset,

        // Code side
        input  wb_req_t i_c_req,
        output logic    o_c_ack,

        // Data side
        input  wb_req_t i_d_req,
        output logic    o_d_ack,

        // Shared bus towards the slave
        output wb_req_t o_req,
        input  logic    i_ack
);

owner_t owner_ff;
owner_t owner_nxt;

// True when the current beat closes a burst or a single transfer
logic eob_ack;

assign eob_ack = i_ack & (o_req.cti == CTI_EOB);

//////////////////////////////////////////////////
// Owner FSM
//////////////////////////////////////////////////

// Hands over at an end-of-burst acknowledge or when the owner is idle
// A burst in progress keeps its strobe high, so it is never cut short
always_comb
begin
        owner_nxt = owner_ff;
        case (owner_ff)
        OWNER_CODE:
        begin
                // Data waits and code just finished its burst
                if (eob_ack && i_d_req.stb)
                begin
                        owner_nxt = OWNER_DATA;
                end
                // Code has nothing to do while data is asking
                else if (!i_c_req.stb && i_d_req.stb)
                begin
                        owner_nxt = OWNER_DATA;
                end
        end
        OWNER_DATA:
        begin
                if (eob_ack && i_c_req.stb)
                begin
                        owner_nxt = OWNER_CODE;
                end
                else if (!i_d_req.stb && i_c_req.stb)
                begin
                        owner_nxt = OWNER_CODE;
                end
        end
        default:
        begin
                owner_nxt = OWNER_CODE;
        end
        endcase
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                owner_ff <= OWNER_CODE;
        end
        else
        begin
                owner_ff <= owner_nxt;
        end
end

//////////////////////////////////////////////////
// Bus mux and acknowledge routing
//////////////////////////////////////////////////

// Both masters drive from flops, so a plain mux on the current owner is enough
assign o_req = (owner_ff == OWNER_CODE) ? i_c_req : i_d_req;

// Only the owner ever sees the acknowledge
assign o_c_ack = (owner_ff == OWNER_CODE) & i_ack;
assign o_d_ack = (owner_ff == OWNER_DATA) & i_ack;

endmodule

// File: wb_sram.sv
// Wishbone SRAM slave with byte-lane writes and a registered one-cycle acknowledge
`timescale 1ns/1ps

module wb_sram import wb_pkg::*;
(
        input  logic    i_clk,
        input  logic    i_reset,
        input  wb_req_t i_req,
        output wb_rsp_t o_rsp
);

// Word storage, contents undefined after reset
word_t mem [MEM_WORDS];

logic              ack_ff;
word_t             rdata_ff;
logic [MEM_AW-1:0] idx;

// A beat is taken on the first cycle of a strobe, never on the ack cycle
logic take;

assign idx  = i_req.adr[MEM_AW+1:2];
assign take = i_req.cyc & i_req.stb & ~ack_ff;

//////////////////////////////////////////////////
// Acknowledge
//////////////////////////////////////////////////

// The ack drops for one cycle after each beat, so every beat is 2 cycles
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                ack_ff <= 1'b0;
        end
        else
        begin
                ack_ff <= take;
        end
end

// Read data and byte-lane writes share the edge that raises the ack
always_ff @(posedge i_clk)
begin
        if (take)
        begin
                rdata_ff <= mem[idx];
                for (int lane = 0; lane < 4; lane++)
                begin
                        if (i_req.wen && i_req.sel[lane])
                        begin
                                mem[idx][lane*8 +: 8] <= i_req.dat[lane*8 +: 8];
                        end
                end
        end
end

assign o_rsp.ack = ack_ff;
assign o_rsp.dat = rdata_ff;

endmodule

// File: wb_subsystem.sv
// Memory subsystem top, fetch and data masters sharing one Wishbone SRAM
`timescale 1ns/1ps

module wb_subsystem import wb_pkg::*;
(
        input  logic  i_clk,
        input  logic  i_reset,

        // Instruction fetch side
        input  logic  i_fetch_start,
        input  addr_t i_fetch_addr,
        output word_t o_fetch_word,
        output logic  o_fetch_valid,
        output logic  o_fetch_done,

        // Data access side
        input  logic  i_data_req,
        input  logic  i_data_wen,
        input  addr_t i_data_addr,
        input  word_t i_data_wdata,
        input  sel_t  i_data_sel,
        output word_t o_data_rdata,
        output logic  o_data_done,
        output logic  o_data_busy
);

wb_req_t code_req;
wb_req_t data_req;
wb_req_t bus_req;
wb_rsp_t bus_rsp;
logic    code_ack;
logic    data_ack;

//////////////////////////////////////////////////
// Masters
//////////////////////////////////////////////////

// Both masters see the same read data, only the ack is steered
code_fetch_unit u_code_fetch_unit (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_start  (i_fetch_start),
        .i_addr   (i_fetch_addr),
        .o_word   (o_fetch_word),
        .o_valid  (o_fetch_valid),
        .o_done   (o_fetch_done),
        .o_wb_req (code_req),
        .i_wb_ack (code_ack),
        .i_wb_dat (bus_rsp.dat)
);

data_access_unit u_data_access_unit (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_req    (i_data_req),
        .i_wen    (i_data_wen),
        .i_addr   (i_data_addr),
        .i_wdata  (i_data_wdata),
        .i_sel    (i_data_sel),
        .o_rdata  (o_data_rdata),
        .o_done   (o_data_done),
        .o_busy   (o_data_busy),
        .o_wb_req (data_req),
        .i_wb_ack (data_ack),
        .i_wb_dat (bus_rsp.dat)
);

//////////////////////////////////////////////////
// Arbitration and memory
//////////////////////////////////////////////////

wb_merger u_wb_merger (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_c_req (code_req),
        .o_c_ack (code_ack),
        .i_d_req (data_req),
        .o_d_ack (data_ack),
        .o_req   (bus_req),
        .i_ack   (bus_rsp.ack)
);

wb_sram u_wb_sram (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_req   (bus_req),
        .o_rsp   (bus_rsp)
);

endmodule

// File: tb_clock_gen.sv
// Testbench clock and reset source, 8 ns clock with a 10-cycle synchronous reset
`timescale 1ns/1ps

module tb_clock_gen
(
        output logic o_clk,
        output logic o_reset
);

localparam int HALF_PERIOD_NS = 4;
localparam int RESET_CYCLES   = 10;

initial
begin
        o_clk = 1'b0;
        forever
        begin
                #(HALF_PERIOD_NS) o_clk = ~o_clk;
        end
end

// Reset is released on a rising edge like any other synchronous input
initial
begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES)
        begin
                @(posedge o_clk);
        end
        o_reset <= 1'b0;
end

endmodule

// File: wb_subsystem_checker.sv
// Wishbone merger checker, protocol assertions on the merged bus and the owner FSM
`timescale 1ns/1ps

module wb_subsystem_checker import wb_pkg::*;
(
        input logic    i_clk,
        input logic    i_reset,
        input logic    i_c_ack,
        input logic    i_d_ack,
        input wb_req_t i_req,
        input logic    i_ack,
        input owner_t  i_owner
);

// Set once an incrementing beat is acknowledged, cleared by any other acknowledge
logic burst_open;

// True on the edge that closes a burst, where a hand-over is allowed
logic eob_ack;

// Covers the first incrementing acknowledge as well as the beats after it
logic in_burst;

// Number of failed assertions so far
int failures = 0;

assign eob_ack  = i_ack & (i_req.cti == CTI_EOB);
assign in_burst = burst_open | (i_ack & (i_req.cti == CTI_INCR));

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                burst_open <= 1'b0;
        end
        else if (i_ack)
        begin
                burst_open <= (i_req.cti == CTI_INCR);
        end
end

//////////////////////////////////////////////////
// Assertions
//////////////////////////////////////////////////

// An acknowledge reaches exactly one master, and only while the bus still strobes
ack_exclusive: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_ack || i_c_ack || i_d_ack) |-> ((i_c_ack ^ i_d_ack) && i_req.stb))
        else
        begin
                failures++;
                $error("acknowledge not routed to exactly one strobing master");
        end

stb_within_cyc: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_req.stb && !i_req.cyc))
        else
        begin
                failures++;
                $error("strobe on the merged bus without an active cycle");
        end

// The owner may only move at the end-of-burst acknowledge
owner_held: assert property (@(posedge i_clk) disable iff (i_reset)
        (in_burst && !eob_ack) |=> $stable(i_owner))
        else
        begin
                failures++;
                $error("bus owner changed while a burst was open");
        end

endmodule

// File: wb_subsystem_tb.sv
// Testbench for the Wishbone memory subsystem, checked against a shadow memory
`timescale 1ns/1ps

module wb_subsystem_tb import wb_pkg::*;
();

//////////////////////////////////////////////////
// Run length
//////////////////////////////////////////////////

localparam int RAND_SEED   = 73429;
localparam int IDLE_CYCLES = 20;
localparam int FULL_WORDS  = 32;
localparam int BYTE_WRITES = 16;
localparam int FETCHES     = 4;
localparam int ROUNDS      = 40;

// Every transfer of the run, preload included and bursts counted per beat
localparam int TRANSFERS = MEM_WORDS + 2 * FULL_WORDS + 2 * BYTE_WRITES
                           + (FETCHES + ROUNDS) * BURST_LEN + ROUNDS;

// A beat is 2 bus cycles, request and hand-over add a few, 8 per transfer leaves margin
localparam int TIMEOUT_CYCLES = TRANSFERS * 8 + IDLE_CYCLES + 200;

logic  clk;
logic  reset;

// DUT inputs
logic  fetch_start;
addr_t fetch_addr;
logic  data_req;
logic  data_wen;
addr_t data_addr;
word_t data_wdata;
sel_t  data_sel;

// DUT outputs
word_t fetch_word;
logic  fetch_valid;
logic  fetch_done;
word_t data_rdata;
logic  data_done;
logic  data_busy;

// Expected memory contents, updated when a write completes
word_t shadow [MEM_WORDS];

// Stimulus side bookkeeping
string cur_test;
int    data_issued = 0;
int    fetch_issued = 0;
logic  exp_wen;
addr_t exp_addr;
word_t exp_wdata;
sel_t  exp_sel;
addr_t exp_fetch_base;
addr_t written [FULL_WORDS];
int    idle_checks = 0;
int    idle_errors = 0;
int    checks_at_start = 0;
int    errors_at_start = 0;
int    tests_run = 0;
int    tests_failed = 0;

// Compare side bookkeeping
int    data_seen = 0;
int    fetch_seen = 0;
int    fetch_beat = 0;
int    cmp_checks = 0;
int    cmp_errors = 0;
int    cycle_count = 0;

// Busy flag as seen on the previous falling edge
logic  busy_prev = 1'b0;

tb_clock_gen u_clock_gen (
        .o_clk   (clk),
        .o_reset (reset)
);

wb_subsystem dut (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_fetch_start (fetch_start),
        .i_fetch_addr  (fetch_addr),
        .o_fetch_word  (fetch_word),
        .o_fetch_valid (fetch_valid),
        .o_fetch_done  (fetch_done),
        .i_data_req    (data_req),
        .i_data_wen    (data_wen),
        .i_data_addr   (data_addr),
        .i_data_wdata  (data_wdata),
        .i_data_sel    (data_sel),
        .o_data_rdata  (data_rdata),
        .o_data_done   (data_done),
        .o_data_busy   (data_busy)
);

// The checker sits inside the merger so it can see the owner state
bind wb_merger wb_subsystem_checker u_checker (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_c_ack (o_c_ack),
        .i_d_ack (o_d_ack),
        .i_req   (o_req),
        .i_ack   (i_ack),
        .i_owner (owner_ff)
);

//////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////

// The SRAM word is chosen by address bits 9:2
function automatic logic [MEM_AW-1:0] word_index(input addr_t addr);
        return addr[MEM_AW+1:2];
endfunction

// Lanes with sel set take the new byte, the others keep the old one
function automatic word_t merge_lanes(input word_t old_word, input word_t new_word,
                                      input sel_t sel);
        word_t merged;
        merged = old_word;
        for (int lane = 0; lane < 4; lane++)
        begin
                if (sel[lane])
                begin
                        merged[lane*8 +: 8] = new_word[lane*8 +: 8];
                end
        end
        return merged;
endfunction

function automatic void shadow_write(input addr_t addr, input word_t data, input sel_t sel);
        shadow[word_index(addr)] = merge_lanes(shadow[word_index(addr)], data, sel);
endfunction

function automatic word_t shadow_read(input addr_t addr);
        return shadow[word_index(addr)];
endfunction

// Each byte mixes the full word index, so aliased addresses show up as wrong data
function automatic word_t fill_pattern(input addr_t addr);
        logic [MEM_AW-1:0] idx;
        idx = word_index(addr);
        return {idx ^ 8'hA5, ~idx, idx + 8'h3C, idx};
endfunction

// Random byte address inside the SRAM, low bits left random on purpose
function automatic addr_t random_addr();
        return addr_t'($urandom) & addr_t'(MEM_WORDS * 4 - 1);
endfunction

// Errors from the comparing process, the idle checks and the bound assertions
function automatic int total_errors();
        return cmp_errors + idle_errors + dut.u_wb_merger.u_checker.failures;
endfunction

//////////////////////////////////////////////////
// Comparing process
//////////////////////////////////////////////////

task automatic compare_word(input string what, input word_t expected, input word_t actual);
        cmp_checks++;
        assert (actual === expected)
        else
        begin
                $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what,
                         expected, actual);
                cmp_errors++;
        end
endtask

// Outputs change on the rising edge, so they are sampled on the falling one
always @(negedge clk)
begin
        if (!reset)
        begin
                if (data_done)
                begin
                        cmp_checks++;
                        assert (data_issued > data_seen)
                        else
                        begin
                                $display("[ERROR] %s: data unit finished with no request open",
                                         cur_test);
                                cmp_errors++;
                        end
                        // A data transfer can never land between the beats of a burst
                        cmp_checks++;
                        assert (fetch_beat == 0)
                        else
                        begin
                                $display("[ERROR] %s: data transfer finished inside a burst",
                                         cur_test);
                                cmp_errors++;
                        end
                        // Busy spans the transfer and drops together with its completion
                        cmp_checks++;
                        assert (busy_prev && !data_busy)
                        else
                        begin
                                $display("[ERROR] %s: busy flag did not span the data transfer",
                                         cur_test);
                                cmp_errors++;
                        end
                        if (exp_wen)
                        begin
                                shadow_write(exp_addr, exp_wdata, exp_sel);
                        end
                        else
                        begin
                                compare_word("read", shadow_read(exp_addr), data_rdata);
                        end
                        data_seen++;
                end
                if (fetch_valid)
                begin
                        cmp_checks++;
                        assert (fetch_issued > fetch_seen && fetch_beat < BURST_LEN)
                        else
                        begin
                                $display("[ERROR] %s: fetch word arrived outside a burst",
                                         cur_test);
                                cmp_errors++;
                        end
                        // Words must come in address order from the aligned start
                        compare_word($sformatf("fetch word %0d", fetch_beat),
                                     shadow_read(exp_fetch_base + addr_t'(4 * fetch_beat)),
                                     fetch_word);
                        fetch_beat++;
                end
                if (fetch_done)
                begin
                        cmp_checks++;
                        assert (fetch_issued > fetch_seen && fetch_beat == BURST_LEN)
                        else
                        begin
                                $display("[ERROR] %s: fetch done after %0d of %0d words",
                                         cur_test, fetch_beat, BURST_LEN);
                                cmp_errors++;
                        end
                        fetch_beat = 0;
                        fetch_seen++;
                end
        end
        busy_prev = data_busy;
end

// Watchdog
always @(posedge clk)
begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
                $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
                $display("Test failed");
                $finish;
        end
end

//////////////////////////////////////////////////
// Stimulus
//////////////////////////////////////////////////

// Called on a rising edge, the request is seen by the DUT on the next one
task automatic drive_data(input logic wen, input addr_t addr, input word_t wdata,
                          input sel_t sel);
        exp_wen   = wen;
        exp_addr  = addr;
        exp_wdata = wdata;
        exp_sel   = sel;
        data_issued++;
        data_req   <= 1'b1;
        data_wen   <= wen;
        data_addr  <= addr;
        data_wdata <= wdata;
        data_sel   <= sel;
endtask

task automatic drive_fetch(input addr_t addr);
        exp_fetch_base = addr & ~addr_t'(3);
        fetch_issued++;
        fetch_start <= 1'b1;
        fetch_addr  <= addr;
endtask

task automatic clear_requests();
        fetch_start <= 1'b0;
        data_req    <= 1'b0;
endtask

// Completion is counted by the comparing process, the watchdog bounds the wait
task automatic wait_all_done();
        while (data_seen < data_issued || fetch_seen < fetch_issued)
        begin
                @(posedge clk);
        end
endtask

task automatic run_data(input logic wen, input addr_t addr, input word_t wdata,
                        input sel_t sel);
        @(posedge clk);
        drive_data(wen, addr, wdata, sel);
        @(posedge clk);
        clear_requests();
        wait_all_done();
endtask

task automatic run_fetch(input addr_t addr);
        @(posedge clk);
        drive_fetch(addr);
        @(posedge clk);
        clear_requests();
        wait_all_done();
endtask

task automatic begin_test(input string name);
        cur_test        = name;
        checks_at_start = cmp_checks + idle_checks;
        errors_at_start = total_errors();
endtask

task automatic end_test();
        int checks;
        int errors;
        checks = cmp_checks + idle_checks - checks_at_start;
        errors = total_errors() - errors_at_start;
        tests_run++;
        if (errors != 0)
        begin
                tests_failed++;
        end
        $display("[done] %s: %0d checks, %0d errors", cur_test, checks, errors);
endtask

initial
begin
        addr_t addr;
        fetch_start = 1'b0;
        fetch_addr  = '0;
        data_req    = 1'b0;
        data_wen    = 1'b0;
        data_addr   = '0;
        data_wdata  = '0;
        data_sel    = '0;
        void'($urandom(RAND_SEED));
        @(posedge clk);
        while (reset)
        begin
                @(posedge clk);
        end

        // Nothing may move on the outputs while no request is pending
        begin_test("reset_idle");
        repeat (IDLE_CYCLES)
        begin
                @(negedge clk);
                idle_checks++;
                assert (!fetch_valid && !fetch_done && !data_done && !data_busy)
                else
                begin
                        $display("[ERROR] %s: an output was active with no request pending",
                                 cur_test);
                        idle_errors++;
                end
        end
        end_test();

        // Fill the whole SRAM so later reads and bursts have known contents
        begin_test("preload");
        for (int w = 0; w < MEM_WORDS; w++)
        begin
                run_data(1'b1, addr_t'(w * 4), fill_pattern(addr_t'(w * 4)), 4'hF);
        end
        end_test();

        begin_test("full_word_rw");
        for (int i = 0; i < FULL_WORDS; i++)
        begin
                written[i] = random_addr();
                run_data(1'b1, written[i], $urandom, 4'hF);
        end
        for (int i = 0; i < FULL_WORDS; i++)
        begin
                run_data(1'b0, written[i], '0, 4'hF);
        end
        end_test();

        begin_test("byte_lane_merge");
        for (int i = 0; i < BYTE_WRITES; i++)
        begin
                addr = random_addr();
                run_data(1'b1, addr, $urandom, sel_t'($urandom_range(0, 15)));
                run_data(1'b0, addr, '0, 4'hF);
        end
        end_test();

        begin_test("fetch_burst");
        for (int i = 0; i < FETCHES; i++)
        begin
                run_fetch(random_addr() & ~addr_t'(3));
        end
        end_test();

        // Both masters start on the same edge and contend for the bus
        begin_test("mixed_traffic");
        for (int r = 0; r < ROUNDS; r++)
        begin
                @(posedge clk);
                drive_fetch(random_addr() & ~addr_t'(3));
                drive_data(1'($urandom_range(0, 1)), random_addr(), $urandom,
                           sel_t'($urandom_range(0, 15)));
                @(posedge clk);
                clear_requests();
                wait_all_done();
        end
        end_test();

        $display("Summary: %0d tests, %0d failing, %0d checks, %0d errors",
                 tests_run, tests_failed, cmp_checks + idle_checks, total_errors());
        if (total_errors() == 0)
        begin
                $display("Test passed");
        end
        else
        begin
                $display("Test failed");
        end
        $finish;
end

endmodule

// File: wb_subsystem.f
wb_pkg.sv
code_fetch_unit.sv
data_access_unit.sv
wb_merger.sv
wb_sram.sv
wb_subsystem.sv
tb_clock_gen.sv
wb_subsystem_checker.sv
wb_subsystem_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= wb_subsystem_tb
FILELIST  ?= wb_subsystem.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator, run it and check the result"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
